// File: source/des_pkg.sv
package des_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int block_w     = 64;
    localparam int half_w      = 32;
    localparam int key_w       = 64;
    localparam int cd_w        = 28;
    localparam int round_key_w = 48;
    localparam int num_rounds  = 16;
    localparam int round_cnt_w = 4;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [half_w-1:0] left;
        logic [half_w-1:0] right;
    } des_halves_t;

    typedef struct packed {
        logic [cd_w-1:0] c;
        logic [cd_w-1:0] d;
    } des_cd_t;

    typedef struct packed {
        logic [block_w-1:0] block;
        logic [key_w-1:0]   key;
        logic               decrypt;
    } des_req_t;

    // Item handed from the input stage to the round engine
    typedef struct packed {
        des_halves_t halves;
        des_cd_t     cd;
        logic        decrypt;
    } des_work_t;

    // ------------------------------------------------------------------
    // Bit-selection tables
    // ------------------------------------------------------------------
    // Entries count from 1 at the most significant bit, as in the standard
    localparam logic [6:0] ip_table [block_w] = '{
        58, 50, 42, 34, 26, 18, 10, 2,  60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,  64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9,  1,  59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,  63, 55, 47, 39, 31, 23, 15, 7
    };

    localparam logic [6:0] ip_inv_table [block_w] = '{
        40, 8, 48, 16, 56, 24, 64, 32,  39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,  37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,  35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,  33, 1, 41, 9,  49, 17, 57, 25
    };

    // Expansion of the right half, 32 to 48 bits
    localparam logic [6:0] e_table [round_key_w] = '{
        32, 1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
        8,  9,  10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam logic [6:0] p_table [half_w] = '{
        16, 7,  20, 21, 29, 12, 28, 17, 1,  15, 23, 26, 5,  18, 31, 10,
        2,  8,  24, 14, 32, 27, 3,  9,  19, 13, 30, 6,  22, 11, 4,  25
    };

    // Drops the eight parity bits of the key
    localparam logic [6:0] pc1_table [2*cd_w] = '{
        57, 49, 41, 33, 25, 17, 9,  1,  58, 50, 42, 34, 26, 18,
        10, 2,  59, 51, 43, 35, 27, 19, 11, 3,  60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7,  62, 54, 46, 38, 30, 22,
        14, 6,  61, 53, 45, 37, 29, 21, 13, 5,  28, 20, 12, 4
    };

    localparam logic [6:0] pc2_table [round_key_w] = '{
        14, 17, 11, 24, 1,  5,  3,  28, 15, 6,  21, 10,
        23, 19, 12, 4,  26, 8,  16, 7,  27, 20, 13, 2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // ------------------------------------------------------------------
    // S-boxes, indexed by {row, column}
    // ------------------------------------------------------------------
    localparam logic [3:0] sbox_table [8][64] = '{
        '{14, 4,  13, 1,  2,  15, 11, 8,  3,  10, 6,  12, 5,  9,  0,  7,
          0,  15, 7,  4,  14, 2,  13, 1,  10, 6,  12, 11, 9,  5,  3,  8,
          4,  1,  14, 8,  13, 6,  2,  11, 15, 12, 9,  7,  3,  10, 5,  0,
          15, 12, 8,  2,  4,  9,  1,  7,  5,  11, 3,  14, 10, 0,  6,  13},
        '{15, 1,  8,  14, 6,  11, 3,  4,  9,  7,  2,  13, 12, 0,  5,  10,
          3,  13, 4,  7,  15, 2,  8,  14, 12, 0,  1,  10, 6,  9,  11, 5,
          0,  14, 7,  11, 10, 4,  13, 1,  5,  8,  12, 6,  9,  3,  2,  15,
          13, 8,  10, 1,  3,  15, 4,  2,  11, 6,  7,  12, 0,  5,  14, 9},
        '{10, 0,  9,  14, 6,  3,  15, 5,  1,  13, 12, 7,  11, 4,  2,  8,
          13, 7,  0,  9,  3,  4,  6,  10, 2,  8,  5,  14, 12, 11, 15, 1,
          13, 6,  4,  9,  8,  15, 3,  0,  11, 1,  2,  12, 5,  10, 14, 7,
          1,  10, 13, 0,  6,  9,  8,  7,  4,  15, 14, 3,  11, 5,  2,  12},
        '{7,  13, 14, 3,  0,  6,  9,  10, 1,  2,  8,  5,  11, 12, 4,  15,
          13, 8,  11, 5,  6,  15, 0,  3,  4,  7,  2,  12, 1,  10, 14, 9,
          10, 6,  9,  0,  12, 11, 7,  13, 15, 1,  3,  14, 5,  2,  8,  4,
          3,  15, 0,  6,  10, 1,  13, 8,  9,  4,  5,  11, 12, 7,  2,  14},
        '{2,  12, 4,  1,  7,  10, 11, 6,  8,  5,  3,  15, 13, 0,  14, 9,
          14, 11, 2,  12, 4,  7,  13, 1,  5,  0,  15, 10, 3,  9,  8,  6,
          4,  2,  1,  11, 10, 13, 7,  8,  15, 9,  12, 5,  6,  3,  0,  14,
          11, 8,  12, 7,  1,  14, 2,  13, 6,  15, 0,  9,  10, 4,  5,  3},
        '{12, 1,  10, 15, 9,  2,  6,  8,  0,  13, 3,  4,  14, 7,  5,  11,
          10, 15, 4,  2,  7,  12, 9,  5,  6,  1,  13, 14, 0,  11, 3,  8,
          9,  14, 15, 5,  2,  8,  12, 3,  7,  0,  4,  10, 1,  13, 11, 6,
          4,  3,  2,  12, 9,  5,  15, 10, 11, 14, 1,  7,  6,  0,  8,  13},
        '{4,  11, 2,  14, 15, 0,  8,  13, 3,  12, 9,  7,  5,  10, 6,  1,
          13, 0,  11, 7,  4,  9,  1,  10, 14, 3,  5,  12, 2,  15, 8,  6,
          1,  4,  11, 13, 12, 3,  7,  14, 10, 15, 6,  8,  0,  5,  9,  2,
          6,  11, 13, 8,  1,  4,  10, 7,  9,  5,  0,  15, 14, 2,  3,  12},
        '{13, 2,  8,  4,  6,  15, 11, 1,  10, 9,  3,  14, 5,  0,  12, 7,
          1,  15, 13, 8,  10, 3,  7,  4,  12, 5,  6,  11, 0,  14, 9,  2,
          7,  11, 4,  1,  9,  12, 14, 2,  0,  6,  10, 13, 15, 3,  5,  8,
          2,  1,  14, 7,  4,  10, 8,  13, 15, 12, 9,  0,  3,  5,  6,  11}
    };

    // Bit i set when round i+1 rotates by one bit (rounds 1, 2, 9, 16)
    localparam logic [num_rounds-1:0] rotate_one = 16'b1000_0001_0000_0011;

endpackage

// File: source/des_input_stage.sv
`timescale 1ns/1ps

module des_input_stage import des_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  des_req_t  in_req,
    output logic      work_valid,
    input  logic      work_ready,
    output des_work_t work
);

    logic [block_w-1:0] ip_out;
    logic [2*cd_w-1:0]  pc1_out;
    logic               accept;

    // Free when empty or when the held item moves on this cycle
    assign in_ready = !work_valid || work_ready;
    assign accept   = in_valid && in_ready;

    // Initial permutation and permuted choice 1
    always_comb begin
        for (int i = 0; i < block_w; i++) begin
            ip_out[block_w-1-i] = in_req.block[block_w-ip_table[i]];
        end
        for (int i = 0; i < 2*cd_w; i++) begin
            pc1_out[2*cd_w-1-i] = in_req.key[key_w-pc1_table[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work_valid <= 1'b0;
        end else if (in_ready) begin
            work_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            work.halves  <= ip_out;
            work.cd      <= pc1_out;
            work.decrypt <= in_req.decrypt;
        end
    end

endmodule

// File: source/des_feistel.sv
`timescale 1ns/1ps

module des_feistel import des_pkg::*; (
    input  logic [half_w-1:0]      right,
    input  logic [round_key_w-1:0] round_key,
    output logic [half_w-1:0]      f_out
);

    logic [round_key_w-1:0] expanded;
    logic [round_key_w-1:0] mixed;
    logic [half_w-1:0]      sb_out;

    // ------------------------------------------------------------------
    // Expansion and key mixing
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < round_key_w; i++) begin
            expanded[round_key_w-1-i] = right[half_w-e_table[i]];
        end
    end

    assign mixed = expanded ^ round_key;

    // ------------------------------------------------------------------
    // S-boxes
    // ------------------------------------------------------------------
    // Row from the two outer bits of each group, column from the inner four
    always_comb begin
        for (int s = 0; s < 8; s++) begin
            sb_out[half_w-1-4*s -: 4] = sbox_table[s][{mixed[47-6*s],
                                                       mixed[42-6*s],
                                                       mixed[46-6*s -: 4]}];
        end
    end

    // ------------------------------------------------------------------
    // Permutation P
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < half_w; i++) begin
            f_out[half_w-1-i] = sb_out[half_w-p_table[i]];
        end
    end

endmodule

// File: source/des_key_schedule.sv
`timescale 1ns/1ps

module des_key_schedule import des_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  des_cd_t                cd_in,
    input  logic                   decrypt,
    input  logic                   advance,
    input  logic [round_cnt_w-1:0] round,
    output logic [round_key_w-1:0] round_key
);

    des_cd_t                cd_q;
    des_cd_t                cd_rot;
    des_cd_t                cd_key;
    logic                   dec_q;
    logic [round_cnt_w-1:0] shift_idx;
    logic                   shift_one;

    function automatic logic [cd_w-1:0] rotl(input logic [cd_w-1:0] v, input logic one);
        return one ? {v[cd_w-2:0], v[cd_w-1]} : {v[cd_w-3:0], v[cd_w-1:cd_w-2]};
    endfunction

    function automatic logic [cd_w-1:0] rotr(input logic [cd_w-1:0] v, input logic one);
        return one ? {v[0], v[cd_w-1:1]} : {v[1:0], v[cd_w-1:2]};
    endfunction

    // Decryption walks the schedule backwards: amount of round 17-i,
    // which for a 4-bit round index is simply its complement
    assign shift_idx = dec_q ? ~round : round;
    assign shift_one = rotate_one[shift_idx];

    always_comb begin
        if (dec_q) begin
            cd_rot.c = rotr(cd_q.c, shift_one);
            cd_rot.d = rotr(cd_q.d, shift_one);
            cd_key   = cd_q;
        end else begin
            cd_rot.c = rotl(cd_q.c, shift_one);
            cd_rot.d = rotl(cd_q.d, shift_one);
            cd_key   = cd_rot;
        end
    end

    // Permuted choice 2
    always_comb begin
        for (int i = 0; i < round_key_w; i++) begin
            round_key[round_key_w-1-i] = cd_key[2*cd_w-pc2_table[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_q <= 1'b0;
        end else if (load) begin
            dec_q <= decrypt;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cd_q <= cd_in;
        end else if (advance) begin
            cd_q <= cd_rot;
        end
    end

endmodule

// File: source/des_round_engine.sv
`timescale 1ns/1ps

module des_round_engine import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        work_valid,
    output logic        work_ready,
    input  des_work_t   work,
    output logic        res_valid,
    input  logic        res_ready,
    output des_halves_t res
);

    logic                   busy_q;
    logic                   done_q;
    logic [round_cnt_w-1:0] round_q;
    des_halves_t            lr_q;
    logic                   load_en;
    logic                   last_round;
    logic [round_key_w-1:0] round_key;
    logic [half_w-1:0]      f_out;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    // Engine is free once its result is leaving, so a new item can load
    // on the same edge
    assign work_ready = !busy_q && (!done_q || res_ready);
    assign load_en    = work_valid && work_ready;
    assign last_round = (round_q == round_cnt_w'(num_rounds - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            round_q <= '0;
        end else if (load_en) begin
            busy_q  <= 1'b1;
            done_q  <= 1'b0;
            round_q <= '0;
        end else if (busy_q) begin
            round_q <= round_q + 1'b1;
            if (last_round) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end else if (done_q && res_ready) begin
            done_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // Feistel datapath
    // ------------------------------------------------------------------
    des_key_schedule u_key_schedule (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_en),
        .cd_in     (work.cd),
        .decrypt   (work.decrypt),
        .advance   (busy_q),
        .round     (round_q),
        .round_key (round_key)
    );

    des_feistel u_feistel (
        .right     (lr_q.right),
        .round_key (round_key),
        .f_out     (f_out)
    );

    always_ff @(posedge clk) begin
        if (load_en) begin
            lr_q <= work.halves;
        end else if (busy_q) begin
            lr_q.left  <= lr_q.right;
            lr_q.right <= lr_q.left ^ f_out;
        end
    end

    // Halves after round 16, swap is left to the output stage
    assign res_valid = done_q;
    assign res       = lr_q;

endmodule

// File: source/des_output_stage.sv
`timescale 1ns/1ps

module des_output_stage import des_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               res_valid,
    output logic               res_ready,
    input  des_halves_t        res,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [block_w-1:0] out_block
);

    logic [block_w-1:0] preout;
    logic [block_w-1:0] final_perm;

    assign res_ready = !out_valid || out_ready;

    // Last step of DES undoes the swap of round 16
    assign preout = {res.right, res.left};

    // Inverse initial permutation
    always_comb begin
        for (int i = 0; i < block_w; i++) begin
            final_perm[block_w-1-i] = preout[block_w-ip_inv_table[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (res_ready) begin
            out_valid <= res_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            out_block <= final_perm;
        end
    end

endmodule

// File: source/des_top.sv
`timescale 1ns/1ps

module des_top import des_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  des_req_t           in_req,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [block_w-1:0] out_block
);

    logic        work_valid;
    logic        work_ready;
    des_work_t   work;
    logic        res_valid;
    logic        res_ready;
    des_halves_t res;

    des_input_stage u_input_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .work_valid (work_valid),
        .work_ready (work_ready),
        .work       (work)
    );

    des_round_engine u_round_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .work_valid (work_valid),
        .work_ready (work_ready),
        .work       (work),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res)
    );

    des_output_stage u_output_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_block  (out_block)
    );

endmodule

// File: bench/des_assertions.sv
`timescale 1ns/1ps

module des_assertions import des_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input logic               in_ready,
    input des_req_t           in_req,
    input logic               out_valid,
    input logic               out_ready,
    input logic [block_w-1:0] out_block
);

    // A waiting request keeps its valid and payload
    property req_held;
        @(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_req);
    endproperty

    // A stalled result keeps its valid and block
    property out_held;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_block);
    endproperty

    property out_valid_known;
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid);
    endproperty

    assert property (req_held) else $error("in_valid or in_req changed before in_ready");
    assert property (out_held) else $error("out_valid or out_block changed while stalled");
    assert property (out_valid_known) else $error("out_valid is unknown");

endmodule

// File: bench/des_tb.sv
`timescale 1ns/1ps

module des_tb import des_pkg::*; ();

    localparam int clk_period = 8;
    // About 40 requests at 17 cycles each plus reset and hold time and a margin
    localparam int watchdog_cycles = 2500;
    localparam int expected_latency = 18;
    localparam int stream_len = 16;

    // Known-answer vectors
    localparam logic [block_w-1:0] kat_plain_a  = 64'h0123456789ABCDEF;
    localparam logic [key_w-1:0]   kat_key_a    = 64'h133457799BBCDFF1;
    localparam logic [block_w-1:0] kat_cipher_a = 64'h85E813540F0AB405;
    localparam logic [block_w-1:0] kat_plain_b  = 64'h8787878787878787;
    localparam logic [key_w-1:0]   kat_key_b    = 64'h0E329232EA6D0D73;
    localparam logic [block_w-1:0] kat_cipher_b = 64'h0000000000000000;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    des_req_t           in_req;
    logic               out_valid;
    logic               out_ready;
    logic [block_w-1:0] out_block;

    integer             seed = 68;
    int                 cyc = 0;
    logic [block_w-1:0] got_q[$];

    des_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_block (out_block)
    );

    bind des_top des_assertions u_assertions (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_block (out_block)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Number of rising edges seen so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Results are taken at the falling edge before their transfer
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            got_q.push_back(out_block);
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        stop_with_error("Timeout, the simulation ran past its time limit");
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic compare_block(input logic [block_w-1:0] expected,
                                 input logic [block_w-1:0] actual,
                                 input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
            stop_with_error("Output block mismatch");
        end
    endtask

    task automatic compare_ready_state(input logic ready_act, input logic valid_act);
        if (ready_act !== 1'b1 || valid_act !== 1'b0) begin
            $display("After reset in_ready should be high and out_valid low, got %b and %b",
                     ready_act, valid_act);
            stop_with_error("Wrong handshake state after reset");
        end
    endtask

    task automatic compare_latency(input int expected, input int actual, input string what);
        if (actual != expected) begin
            $display("Fail at %0t ns: %s expected %0d edges, got %0d",
                     $time, what, expected, actual);
            stop_with_error("Latency mismatch");
        end
    endtask

    function automatic des_req_t make_req(input logic [block_w-1:0] block,
                                          input logic [key_w-1:0] key,
                                          input logic decrypt);
        des_req_t r;
        r.block   = block;
        r.key     = key;
        r.decrypt = decrypt;
        return r;
    endfunction

    // Holds the request until the DUT takes it and returns the accepting edge
    task automatic send_req(input des_req_t req, output int accept_edge);
        logic accepted;
        accepted = 1'b0;
        in_valid = 1'b1;
        in_req   = req;
        while (!accepted) begin
            @(negedge clk);
            if (in_ready) begin
                accepted    = 1'b1;
                accept_edge = cyc + 1;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_results(input int count, input int limit);
        int waited;
        waited = 0;
        while (got_q.size() < count) begin
            @(negedge clk);
            waited++;
            if (waited > limit) begin
                stop_with_error("Timeout while waiting for output blocks");
            end
        end
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic check_reset_state();
        @(negedge clk);
        compare_ready_state(in_ready, out_valid);
        @(posedge clk);
        #1;
    endtask

    task automatic known_answer_test();
        int e;
        got_q.delete();
        send_req(make_req(kat_plain_a, kat_key_a, 1'b0), e);
        send_req(make_req(kat_plain_b, kat_key_b, 1'b0), e);
        send_req(make_req(kat_cipher_a, kat_key_a, 1'b1), e);
        send_req(make_req(kat_cipher_b, kat_key_b, 1'b1), e);
        wait_results(4, 120);
        compare_block(kat_cipher_a, got_q[0], "encipher vector a");
        compare_block(kat_cipher_b, got_q[1], "encipher vector b");
        compare_block(kat_plain_a, got_q[2], "decipher vector a");
        compare_block(kat_plain_b, got_q[3], "decipher vector b");
    endtask

    task automatic latency_test();
        int acc_edge;
        int waited;
        got_q.delete();
        out_ready = 1'b1;
        send_req(make_req(kat_plain_a, kat_key_a, 1'b0), acc_edge);
        waited = 0;
        @(negedge clk);
        while (!out_valid) begin
            waited++;
            if (waited > 40) begin
                stop_with_error("out_valid never rose after a single request");
            end
            @(negedge clk);
        end
        compare_latency(expected_latency, cyc - acc_edge, "single request");
        wait_results(1, 10);
        compare_block(kat_cipher_a, got_q[0], "latency test block");
    endtask

    task automatic random_stream_test();
        logic [block_w-1:0] plain [stream_len];
        logic [key_w-1:0]   keys [stream_len];
        logic [block_w-1:0] cipher [stream_len];
        int                 e;
        got_q.delete();
        for (int i = 0; i < stream_len; i++) begin
            plain[i] = {$random(seed), $random(seed)};
            keys[i]  = {$random(seed), $random(seed)};
            send_req(make_req(plain[i], keys[i], 1'b0), e);
        end
        wait_results(stream_len, stream_len * 20 + 40);
        for (int i = 0; i < stream_len; i++) begin
            cipher[i] = got_q[i];
        end
        got_q.delete();
        for (int i = 0; i < stream_len; i++) begin
            send_req(make_req(cipher[i], keys[i], 1'b1), e);
        end
        wait_results(stream_len, stream_len * 20 + 40);
        for (int i = 0; i < stream_len; i++) begin
            compare_block(plain[i], got_q[i], "stream round trip");
        end
    endtask

    task automatic backpressure_test();
        int e;
        got_q.delete();
        out_ready = 1'b0;
        send_req(make_req(kat_plain_a, kat_key_a, 1'b0), e);
        send_req(make_req(kat_plain_b, kat_key_b, 1'b0), e);
        send_req(make_req(kat_cipher_a, kat_key_a, 1'b1), e);
        @(negedge clk);
        if (in_ready !== 1'b0 || out_valid !== 1'b1) begin
            stop_with_error("in_ready did not drop with the output stalled");
        end
        compare_block(kat_cipher_a, out_block, "stalled output");
        // Long enough for the second block to finish its rounds
        repeat (24) begin
            @(negedge clk);
            if (in_ready !== 1'b0 || out_valid !== 1'b1) begin
                stop_with_error("Handshake flags changed while the output was stalled");
            end
            compare_block(kat_cipher_a, out_block, "stalled output");
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        wait_results(3, 80);
        compare_block(kat_cipher_a, got_q[0], "first stalled result");
        compare_block(kat_cipher_b, got_q[1], "second stalled result");
        compare_block(kat_plain_a, got_q[2], "third stalled result");
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_reset_state();
        known_answer_test();
        latency_test();
        random_stream_test();
        backpressure_test();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: des.f
source/des_pkg.sv
source/des_input_stage.sv
source/des_feistel.sv
source/des_key_schedule.sv
source/des_round_engine.sv
source/des_output_stage.sv
source/des_top.sv
bench/des_assertions.sv
bench/des_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DES testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f des.f --top-module des_tb \
    -Mdir obj_dir -o des_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/des_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
